// File: sources.f
src/axi_bridge_pkg.sv
src/fetch_port.sv
src/data_port.sv
src/axi_bridge_arb.sv
src/cpu_axi_bridge.sv
test/tb_clock_gen.sv
test/axi_mem_model.sv
test/cpu_axi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module cpu_axi_bridge_tb -f sources.f -o cpu_axi_bridge_sim &&
./obj_dir/cpu_axi_bridge_sim | tee sim.log &&
grep -qx "Simulation passed" sim.log &&
echo "run ok" ||
{ echo "run failed, see sim.log"; exit 1; }

// File: test/cpu_axi_bridge_tb.sv
`timescale 1ns/10ps

module cpu_axi_bridge_tb
   import axi_bridge_pkg::*;
();

   localparam int idx_w        = 8;
   localparam int n_tests      = 6;
   localparam int max_txn      = 40;
   localparam int worst_cycles = 64;
   localparam int clk_period   = 8;

   logic aclk;
   logic rst_n;
   // core side
   logic              inst_req;
   logic [addr_w-1:0] inst_addr;
   logic              inst_cancel;
   logic              inst_addr_ok;
   logic              inst_valid;
   logic [data_w-1:0] inst_rdata;
   logic              data_req;
   logic              data_wr;
   logic [addr_w-1:0] data_addr;
   logic [data_w-1:0] data_wdata;
   logic [strb_w-1:0] data_wstrb;
   logic              data_addr_ok;
   logic              data_data_ok;
   logic [data_w-1:0] data_rdata;
   // axi
   logic [id_w-1:0]    arid;
   logic [addr_w-1:0]  araddr;
   logic [len_w-1:0]   arlen;
   logic [size_w-1:0]  arsize;
   logic [burst_w-1:0] arburst;
   logic [lock_w-1:0]  arlock;
   logic [cache_w-1:0] arcache;
   logic [prot_w-1:0]  arprot;
   logic               arvalid;
   logic               arready;
   logic [id_w-1:0]    rid;
   logic [data_w-1:0]  rdata;
   logic [resp_w-1:0]  rresp;
   logic               rlast;
   logic               rvalid;
   logic               rready;
   logic [id_w-1:0]    awid;
   logic [addr_w-1:0]  awaddr;
   logic [len_w-1:0]   awlen;
   logic [size_w-1:0]  awsize;
   logic [burst_w-1:0] awburst;
   logic [lock_w-1:0]  awlock;
   logic [cache_w-1:0] awcache;
   logic [prot_w-1:0]  awprot;
   logic               awvalid;
   logic               awready;
   logic [id_w-1:0]    wid;
   logic [data_w-1:0]  wdata;
   logic [strb_w-1:0]  wstrb;
   logic               wlast;
   logic               wvalid;
   logic               wready;
   logic [id_w-1:0]    bid;
   logic [resp_w-1:0]  bresp;
   logic               bvalid;
   logic               bready;

   // expected memory contents
   logic [data_w-1:0] shadow [0:(1<<idx_w)-1];
   logic [31:0]       lcg_state = 32'd98676;
   int errors = 0;
   int checks = 0;
   int inst_valid_cnt = 0;
   int data_ok_cnt = 0;
   int fetch_beat_cnt = 0;

   tb_clock_gen clk_gen (.aclk, .rst_n);
   cpu_axi_bridge dut (.*);
   axi_mem_model mem_model (.*);

   // pulse counts taken mid-cycle, read by tests only after a rising edge
   always @(negedge aclk) begin
      if (inst_valid) inst_valid_cnt++;
      if (data_data_ok) data_ok_cnt++;
      if (rvalid && rready && rid == fetch_id) fetch_beat_cnt++;
   end

   function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
      return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
   endfunction

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [data_w-1:0] shadow_word(input logic [addr_w-1:0] a);
      return shadow[a[idx_w+1:2]];
   endfunction

   task automatic shadow_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                               input logic [strb_w-1:0] s);
      for (int b = 0; b < strb_w; b++) begin
         if (s[b]) shadow[a[idx_w+1:2]][8*b +: 8] = d[8*b +: 8];
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_event(input bit seen, input string what);
      checks++;
      assert (seen) else begin
         errors++;
         $display("error at %0t: %s", $time, what);
      end
   endtask

   // 1 ns past the rising edge, where inputs change
   task automatic step();
      @(posedge aclk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) step();
   endtask

   // addr_ok seen mid-cycle, the request is taken at the next edge
   task automatic accept_wait(input bit inst_side);
      int n;
      n = 0;
      @(negedge aclk);
      while (!(inst_side ? inst_addr_ok : data_addr_ok) && n < worst_cycles) begin
         n++;
         @(negedge aclk);
      end
      check_event(inst_side ? inst_addr_ok : data_addr_ok, "request was never accepted");
      step();
   endtask

   task automatic wait_done(input bit inst_side, output logic [data_w-1:0] word);
      int n;
      n = 0;
      @(negedge aclk);
      while (!(inst_side ? inst_valid : data_data_ok) && n < worst_cycles) begin
         n++;
         @(negedge aclk);
      end
      check_event(inst_side ? inst_valid : data_data_ok, "no response came back in time");
      word = inst_side ? inst_rdata : data_rdata;
      step();
   endtask

   task automatic fetch_issue(input logic [addr_w-1:0] a);
      inst_req  = 1'b1;
      inst_addr = a;
      accept_wait(1'b1);
      inst_req  = 1'b0;
   endtask

   task automatic data_issue(input bit wr, input logic [addr_w-1:0] a,
                             input logic [data_w-1:0] d, input logic [strb_w-1:0] s);
      data_req   = 1'b1;
      data_wr    = wr;
      data_addr  = a;
      data_wdata = d;
      data_wstrb = s;
      accept_wait(1'b0);
      data_req   = 1'b0;
   endtask

   task automatic fetch_check(input logic [addr_w-1:0] a);
      logic [data_w-1:0] w;
      fetch_issue(a);
      wait_done(1'b1, w);
      check_value("inst_rdata", shadow_word(a), w);
   endtask

   task automatic data_read_check(input logic [addr_w-1:0] a);
      logic [data_w-1:0] w;
      data_issue(1'b0, a, '0, '0);
      wait_done(1'b0, w);
      check_value("data_rdata", shadow_word(a), w);
   endtask

   task automatic data_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                             input logic [strb_w-1:0] s);
      logic [data_w-1:0] w;
      data_issue(1'b1, a, d, s);
      wait_done(1'b0, w);
      shadow_write(a, d, s);
   endtask

   task automatic outputs_idle();
      check_value("arvalid", 0, 32'(arvalid));
      check_value("awvalid", 0, 32'(awvalid));
      check_value("wvalid", 0, 32'(wvalid));
      check_value("inst_valid", 0, 32'(inst_valid));
      check_value("data_data_ok", 0, 32'(data_data_ok));
      check_value("inst_addr_ok", 0, 32'(inst_addr_ok));
      check_value("data_addr_ok", 0, 32'(data_addr_ok));
   endtask

   // single beat of 4 bytes, incr, normal access, writes tagged data_id
   task automatic axi_fields_check();
      check_value("arlen", 0, 32'(arlen));
      check_value("arsize", 2, 32'(arsize));
      check_value("arburst", 1, 32'(arburst));
      check_value("arlock", 0, 32'(arlock));
      check_value("arcache", 0, 32'(arcache));
      check_value("arprot", 0, 32'(arprot));
      check_value("awlen", 0, 32'(awlen));
      check_value("awsize", 2, 32'(awsize));
      check_value("awburst", 1, 32'(awburst));
      check_value("awlock", 0, 32'(awlock));
      check_value("awcache", 0, 32'(awcache));
      check_value("awprot", 0, 32'(awprot));
      check_value("awid", 32'(data_id), 32'(awid));
      check_value("wid", 32'(data_id), 32'(wid));
      check_value("wlast", 1, 32'(wlast));
   endtask

   task automatic test_reset();
      // first look once the clock has run an edge in reset
      @(posedge aclk);
      @(negedge aclk);
      while (!rst_n) begin
         outputs_idle();
         @(negedge aclk);
      end
      // first cycle out of reset
      outputs_idle();
      check_value("rready", 1, 32'(rready));
      check_value("bready", 1, 32'(bready));
      axi_fields_check();
      step();
   endtask

   task automatic test_fetch_read();
      int base;
      base = inst_valid_cnt;
      fetch_check(32'h0000_0040);
      idle_cycles(16);
      check_value("inst_valid pulses", base + 1, inst_valid_cnt);
   endtask

   task automatic test_write_read();
      int base;
      base = data_ok_cnt;
      data_write(32'h0000_0084, 32'hdead_beef, 4'b0101);
      idle_cycles(4);
      check_value("data_data_ok pulses", base + 1, data_ok_cnt);
      data_read_check(32'h0000_0084);
      data_write(32'h0000_0188, 32'h1234_5678, 4'b1000);
      data_read_check(32'h0000_0188);
   endtask

   task automatic test_concurrent();
      int n;
      fork
         fetch_check(32'h0000_0100);
         data_read_check(32'h0000_0204);
         begin
            // data must win the first ar slot
            @(negedge aclk);
            for (n = 0; n < worst_cycles && !arvalid; n++) @(negedge aclk);
            check_event(arvalid, "no read address issued");
            check_value("arid", 32'(data_id), 32'(arid));
         end
      join
   endtask

   task automatic test_cancel();
      int base;
      int beats;
      int n;
      base  = inst_valid_cnt;
      beats = fetch_beat_cnt;
      fetch_issue(32'h0000_0300);
      inst_cancel = 1'b1;
      step();
      inst_cancel = 1'b0;
      for (n = 0; n < worst_cycles && fetch_beat_cnt == beats; n++) step();
      check_event(fetch_beat_cnt != beats, "cancelled fetch never got its read beat");
      idle_cycles(4);
      check_value("inst_valid pulses", base, inst_valid_cnt);
      fetch_check(32'h0000_0304);
   endtask

   task automatic test_random_mix();
      logic [31:0]       r;
      logic [addr_w-1:0] a;
      int                i;
      for (i = 0; i < max_txn; i++) begin
         r = next_random();
         a = {22'b0, r[25:18], 2'b00};
         case (r[29:28])
            2'd0, 2'd1: data_write(a, next_random(), r[15:12]);
            2'd2: data_read_check(a);
            default: fetch_check(a);
         endcase
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      $display("test %s finished, %0d errors", name, errors - errors_before);
   endtask

   initial begin
      int e;
      inst_req    = 1'b0;
      inst_addr   = '0;
      inst_cancel = 1'b0;
      data_req    = 1'b0;
      data_wr     = 1'b0;
      data_addr   = '0;
      data_wdata  = '0;
      data_wstrb  = '0;
      // same preload as the memory model
      for (int w = 0; w < (1 << idx_w); w++) begin
         shadow[w] = fill_word(addr_w'(w << 2));
      end

      e = errors;
      test_reset();
      end_test("reset", e);
      e = errors;
      test_fetch_read();
      end_test("fetch_read", e);
      e = errors;
      test_write_read();
      end_test("write_read", e);
      e = errors;
      test_concurrent();
      end_test("concurrent", e);
      e = errors;
      test_cancel();
      end_test("cancel", e);
      e = errors;
      test_random_mix();
      end_test("random_mix", e);

      $display("checks passed %0d, failed %0d", checks - errors, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // every test, every transaction at worst-case latency
   initial begin
      #(n_tests * max_txn * worst_cycles * clk_period);
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model
   import axi_bridge_pkg::*;
(
   input  logic              aclk,
   input  logic              rst_n,
   // ar
   input  logic [id_w-1:0]   arid,
   input  logic [addr_w-1:0] araddr,
   input  logic              arvalid,
   output logic              arready,
   // r
   output logic [id_w-1:0]   rid,
   output logic [data_w-1:0] rdata,
   output logic [resp_w-1:0] rresp,
   output logic              rlast,
   output logic              rvalid,
   input  logic              rready,
   // aw
   input  logic [id_w-1:0]   awid,
   input  logic [addr_w-1:0] awaddr,
   input  logic              awvalid,
   output logic              awready,
   // w
   input  logic [id_w-1:0]   wid,
   input  logic [data_w-1:0] wdata,
   input  logic [strb_w-1:0] wstrb,
   input  logic              wlast,
   input  logic              wvalid,
   output logic              wready,
   // b
   output logic [id_w-1:0]   bid,
   output logic [resp_w-1:0] bresp,
   output logic              bvalid,
   input  logic              bready
);

   // 256 words, addresses wrap at 1 KiB
   localparam int idx_w     = 8;
   localparam int mem_words = 1 << idx_w;

   logic [data_w-1:0] mem [0:mem_words-1];
   logic [31:0]       seed = 32'd98676;
   logic [id_w-1:0]   rd_id_q [$];
   logic [addr_w-1:0] rd_addr_q [$];
   logic [addr_w-1:0] ra;
   logic [idx_w-1:0]  wi;
   int                r_wait;
   int                b_wait;
   logic              aw_got;
   logic              w_got;
   logic [id_w-1:0]   aw_id;
   logic [addr_w-1:0] aw_addr;
   logic [data_w-1:0] w_data;
   logic [strb_w-1:0] w_strb;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // word depends on every address bit
   function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
      return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
   endfunction

   always @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b0;
         awready <= 1'b0;
         wready  <= 1'b0;
         rvalid  <= 1'b0;
         bvalid  <= 1'b0;
         rid     <= '0;
         rdata   <= '0;
         rresp   <= '0;
         rlast   <= 1'b1;
         bid     <= '0;
         bresp   <= '0;
         aw_got  <= 1'b0;
         w_got   <= 1'b0;
         r_wait  <= 0;
         b_wait  <= 0;
         rd_id_q.delete();
         rd_addr_q.delete();
         // preload while in reset
         for (int w = 0; w < mem_words; w++) begin
            mem[w] = fill_word(addr_w'(w << 2));
         end
      end else begin
         seed = lcg_step(seed);
         // ready about three cycles in four
         arready <= seed[17:16] != 2'b00;
         awready <= !aw_got && seed[19:18] != 2'b00;
         wready  <= !w_got && seed[21:20] != 2'b00;

         // queue reads, answered in arrival order
         if (arvalid && arready) begin
            rd_id_q.push_back(arid);
            rd_addr_q.push_back(araddr);
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            r_wait <= int'(seed[24:22]);
         end else if (!rvalid && rd_id_q.size() > 0) begin
            if (r_wait > 0) begin
               r_wait <= r_wait - 1;
            end else begin
               ra = rd_addr_q.pop_front();
               rid    <= rd_id_q.pop_front();
               rdata  <= mem[ra[idx_w+1:2]];
               rvalid <= 1'b1;
            end
         end

         // aw and w may arrive in either order
         if (awvalid && awready) begin
            aw_got  <= 1'b1;
            aw_id   <= awid;
            aw_addr <= awaddr;
         end
         if (wvalid && wready) begin
            w_got  <= 1'b1;
            w_data <= wdata;
            w_strb <= wstrb;
         end
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_wait <= int'(seed[27:25]);
         end else if (aw_got && w_got && !bvalid) begin
            if (b_wait > 0) begin
               b_wait <= b_wait - 1;
            end else begin
               wi = aw_addr[idx_w+1:2];
               for (int b = 0; b < strb_w; b++) begin
                  if (w_strb[b]) mem[wi][8*b +: 8] = w_data[8*b +: 8];
               end
               aw_got <= 1'b0;
               w_got  <= 1'b0;
               bid    <= aw_id;
               bvalid <= 1'b1;
            end
         end
      end
   end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
   output logic aclk,
   output logic rst_n
);

   // 8 ns clock
   localparam int half_period  = 4;
   localparam int reset_cycles = 10;

   initial begin
      aclk = 1'b0;
      forever #half_period aclk = ~aclk;
   end

   // release just after an edge, away from any sampling point
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge aclk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: src/cpu_axi_bridge.sv
`timescale 1ns/10ps

module cpu_axi_bridge
   import axi_bridge_pkg::*;
(
   input  logic               aclk,
   input  logic               rst_n,
   // instruction port
   input  logic               inst_req,
   input  logic [addr_w-1:0]  inst_addr,
   input  logic               inst_cancel,
   output logic               inst_addr_ok,
   output logic               inst_valid,
   output logic [data_w-1:0]  inst_rdata,
   // data port
   input  logic               data_req,
   input  logic               data_wr,
   input  logic [addr_w-1:0]  data_addr,
   input  logic [data_w-1:0]  data_wdata,
   input  logic [strb_w-1:0]  data_wstrb,
   output logic               data_addr_ok,
   output logic               data_data_ok,
   output logic [data_w-1:0]  data_rdata,
   // ar
   output logic [id_w-1:0]    arid,
   output logic [addr_w-1:0]  araddr,
   output logic [len_w-1:0]   arlen,
   output logic [size_w-1:0]  arsize,
   output logic [burst_w-1:0] arburst,
   output logic [lock_w-1:0]  arlock,
   output logic [cache_w-1:0] arcache,
   output logic [prot_w-1:0]  arprot,
   output logic               arvalid,
   input  logic               arready,
   // r
   input  logic [id_w-1:0]    rid,
   input  logic [data_w-1:0]  rdata,
   input  logic [resp_w-1:0]  rresp,
   input  logic               rlast,
   input  logic               rvalid,
   output logic               rready,
   // aw
   output logic [id_w-1:0]    awid,
   output logic [addr_w-1:0]  awaddr,
   output logic [len_w-1:0]   awlen,
   output logic [size_w-1:0]  awsize,
   output logic [burst_w-1:0] awburst,
   output logic [lock_w-1:0]  awlock,
   output logic [cache_w-1:0] awcache,
   output logic [prot_w-1:0]  awprot,
   output logic               awvalid,
   input  logic               awready,
   // w
   output logic [id_w-1:0]    wid,
   output logic [data_w-1:0]  wdata,
   output logic [strb_w-1:0]  wstrb,
   output logic               wlast,
   output logic               wvalid,
   input  logic               wready,
   // b
   input  logic [id_w-1:0]    bid,
   input  logic [resp_w-1:0]  bresp,
   input  logic               bvalid,
   output logic               bready
);

   logic              fetch_rd_valid;
   logic [addr_w-1:0] fetch_rd_addr;
   logic              fetch_rd_grant;
   logic              fetch_rd_done;
   logic [data_w-1:0] fetch_rd_data;
   logic              data_op_valid;
   logic              data_op_write;
   logic [addr_w-1:0] data_op_addr;
   logic [data_w-1:0] data_op_wdata;
   logic [strb_w-1:0] data_op_wstrb;
   logic              data_op_grant;
   logic              data_op_done;
   logic [data_w-1:0] data_op_rdata;

   // single beat, 4 bytes, incr, normal unprivileged access
   assign arlen   = {len_w{1'b0}};
   assign arsize  = axi_size_word;
   assign arburst = axi_burst_incr;
   assign arlock  = {lock_w{1'b0}};
   assign arcache = {cache_w{1'b0}};
   assign arprot  = {prot_w{1'b0}};
   assign awlen   = {len_w{1'b0}};
   assign awsize  = axi_size_word;
   assign awburst = axi_burst_incr;
   assign awlock  = {lock_w{1'b0}};
   assign awcache = {cache_w{1'b0}};
   assign awprot  = {prot_w{1'b0}};

   fetch_port u_fetch_port (
      .aclk           (aclk),
      .rst_n          (rst_n),
      .inst_req       (inst_req),
      .inst_addr      (inst_addr),
      .inst_cancel    (inst_cancel),
      .inst_addr_ok   (inst_addr_ok),
      .inst_valid     (inst_valid),
      .inst_rdata     (inst_rdata),
      .fetch_rd_valid (fetch_rd_valid),
      .fetch_rd_addr  (fetch_rd_addr),
      .fetch_rd_grant (fetch_rd_grant),
      .fetch_rd_done  (fetch_rd_done),
      .fetch_rd_data  (fetch_rd_data)
   );

   data_port u_data_port (
      .aclk          (aclk),
      .rst_n         (rst_n),
      .data_req      (data_req),
      .data_wr       (data_wr),
      .data_addr     (data_addr),
      .data_wdata    (data_wdata),
      .data_wstrb    (data_wstrb),
      .data_addr_ok  (data_addr_ok),
      .data_data_ok  (data_data_ok),
      .data_rdata    (data_rdata),
      .data_op_valid (data_op_valid),
      .data_op_write (data_op_write),
      .data_op_addr  (data_op_addr),
      .data_op_wdata (data_op_wdata),
      .data_op_wstrb (data_op_wstrb),
      .data_op_grant (data_op_grant),
      .data_op_done  (data_op_done),
      .data_op_rdata (data_op_rdata)
   );

   axi_bridge_arb u_arb (
      .aclk           (aclk),
      .rst_n          (rst_n),
      .fetch_rd_valid (fetch_rd_valid),
      .fetch_rd_addr  (fetch_rd_addr),
      .fetch_rd_grant (fetch_rd_grant),
      .fetch_rd_done  (fetch_rd_done),
      .fetch_rd_data  (fetch_rd_data),
      .data_op_valid  (data_op_valid),
      .data_op_write  (data_op_write),
      .data_op_addr   (data_op_addr),
      .data_op_wdata  (data_op_wdata),
      .data_op_wstrb  (data_op_wstrb),
      .data_op_grant  (data_op_grant),
      .data_op_done   (data_op_done),
      .data_op_rdata  (data_op_rdata),
      .arid           (arid),
      .araddr         (araddr),
      .arvalid        (arvalid),
      .arready        (arready),
      .rid            (rid),
      .rdata          (rdata),
      .rresp          (rresp),
      .rlast          (rlast),
      .rvalid         (rvalid),
      .rready         (rready),
      .awid           (awid),
      .awaddr         (awaddr),
      .awvalid        (awvalid),
      .awready        (awready),
      .wid            (wid),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .wlast          (wlast),
      .wvalid         (wvalid),
      .wready         (wready),
      .bid            (bid),
      .bresp          (bresp),
      .bvalid         (bvalid),
      .bready         (bready)
   );

endmodule

// File: src/axi_bridge_arb.sv
`timescale 1ns/10ps

module axi_bridge_arb
   import axi_bridge_pkg::*;
(
   input  logic              aclk,
   input  logic              rst_n,
   // fetch requester
   input  logic              fetch_rd_valid,
   input  logic [addr_w-1:0] fetch_rd_addr,
   output logic              fetch_rd_grant,
   output logic              fetch_rd_done,
   output logic [data_w-1:0] fetch_rd_data,
   // data requester
   input  logic              data_op_valid,
   input  logic              data_op_write,
   input  logic [addr_w-1:0] data_op_addr,
   input  logic [data_w-1:0] data_op_wdata,
   input  logic [strb_w-1:0] data_op_wstrb,
   output logic              data_op_grant,
   output logic              data_op_done,
   output logic [data_w-1:0] data_op_rdata,
   // ar
   output logic [id_w-1:0]   arid,
   output logic [addr_w-1:0] araddr,
   output logic              arvalid,
   input  logic              arready,
   // r
   input  logic [id_w-1:0]   rid,
   input  logic [data_w-1:0] rdata,
   input  logic [resp_w-1:0] rresp,
   input  logic              rlast,
   input  logic              rvalid,
   output logic              rready,
   // aw
   output logic [id_w-1:0]   awid,
   output logic [addr_w-1:0] awaddr,
   output logic              awvalid,
   input  logic              awready,
   // w
   output logic [id_w-1:0]   wid,
   output logic [data_w-1:0] wdata,
   output logic [strb_w-1:0] wstrb,
   output logic              wlast,
   output logic              wvalid,
   input  logic              wready,
   // b
   input  logic [id_w-1:0]   bid,
   input  logic [resp_w-1:0] bresp,
   input  logic              bvalid,
   output logic              bready
);

   logic              ar_free;
   logic              wr_free;
   logic              data_rd_grant;
   logic              data_wr_grant;
   logic              r_beat;
   logic [data_w-1:0] r_word;
   logic              data_r_hit;
   logic              data_b_hit;

   // one ar in flight, new grant only once the old one is taken
   assign ar_free = ~arvalid;
   // aw and w both drained before the next write
   assign wr_free = ~awvalid & ~wvalid;

   // data wins the ar channel, writes never block fetch
   assign data_rd_grant  = data_op_valid & ~data_op_write & ar_free;
   assign data_wr_grant  = data_op_valid & data_op_write & wr_free;
   assign data_op_grant  = data_rd_grant | data_wr_grant;
   assign fetch_rd_grant = fetch_rd_valid & ar_free & ~(data_op_valid & ~data_op_write);

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         arvalid <= 1'b0;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end else begin
         if (data_rd_grant || fetch_rd_grant) begin
            arvalid <= 1'b1;
         end else if (arready) begin
            arvalid <= 1'b0;
         end
         // aw and w rise together, drop each on its own ready
         if (data_wr_grant) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
         end else begin
            if (awready) awvalid <= 1'b0;
            if (wready) wvalid <= 1'b0;
         end
      end
   end

   // channel payload registers, held while valid is up
   always_ff @(posedge aclk) begin
      if (data_rd_grant) begin
         araddr <= data_op_addr;
         arid   <= data_id;
      end else if (fetch_rd_grant) begin
         araddr <= fetch_rd_addr;
         arid   <= fetch_id;
      end
      if (data_wr_grant) begin
         awaddr <= data_op_addr;
         wdata  <= data_op_wdata;
         wstrb  <= data_op_wstrb;
      end
   end

   // writes only ever come from the data side
   assign awid  = data_id;
   assign wid   = data_id;
   assign wlast = 1'b1;

   // responses always accepted
   assign rready = 1'b1;
   assign bready = 1'b1;

   assign r_beat = rvalid & rready & rlast;
   // slverr or decerr reads back as all ones
   assign r_word = rresp[1] ? {data_w{1'b1}} : rdata;

   // route by id
   assign fetch_rd_done = r_beat & (rid == fetch_id);
   assign fetch_rd_data = r_word;
   assign data_r_hit    = r_beat & (rid == data_id);
   assign data_b_hit    = bvalid & bready & (bid == data_id);
   assign data_op_done  = data_r_hit | data_b_hit;
   // write status rides in the low bits on a b beat
   assign data_op_rdata = data_b_hit ? {{(data_w-resp_w){1'b0}}, bresp} : r_word;

endmodule

// File: src/data_port.sv
`timescale 1ns/10ps

module data_port
   import axi_bridge_pkg::*;
(
   input  logic              aclk,
   input  logic              rst_n,
   // core side
   input  logic              data_req,
   input  logic              data_wr,
   input  logic [addr_w-1:0] data_addr,
   input  logic [data_w-1:0] data_wdata,
   input  logic [strb_w-1:0] data_wstrb,
   output logic              data_addr_ok,
   output logic              data_data_ok,
   output logic [data_w-1:0] data_rdata,
   // arbiter side
   output logic              data_op_valid,
   output logic              data_op_write,
   output logic [addr_w-1:0] data_op_addr,
   output logic [data_w-1:0] data_op_wdata,
   output logic [strb_w-1:0] data_op_wstrb,
   input  logic              data_op_grant,
   input  logic              data_op_done,
   input  logic [data_w-1:0] data_op_rdata
);

   logic [slot_w-1:0] state;
   logic [slot_w-1:0] state_nxt;
   logic              write_q;
   logic [addr_w-1:0] addr_q;
   logic [data_w-1:0] wdata_q;
   logic [strb_w-1:0] wstrb_q;

   assign data_addr_ok  = data_req & (state == slot_empty);
   assign data_op_valid = (state == slot_wait_grant);

   // whole request held as one until done
   assign data_op_write = write_q;
   assign data_op_addr  = addr_q;
   assign data_op_wdata = wdata_q;
   assign data_op_wstrb = wstrb_q;

   always_comb begin
      state_nxt = state;
      case (state)
         slot_empty: begin
            if (data_addr_ok) state_nxt = slot_wait_grant;
         end
         slot_wait_grant: begin
            if (data_op_grant) state_nxt = slot_wait_data;
         end
         slot_wait_data: begin
            if (data_op_done) state_nxt = slot_empty;
         end
         default: state_nxt = slot_empty;
      endcase
   end

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= slot_empty;
         write_q      <= 1'b0;
         data_data_ok <= 1'b0;
      end else begin
         state <= state_nxt;
         // direction kept with the slot, not sampled again later
         if (data_addr_ok) write_q <= data_wr;
         // one pulse per op, read or write
         data_data_ok <= data_op_done;
      end
   end

   // request payload
   always_ff @(posedge aclk) begin
      if (data_addr_ok) begin
         addr_q  <= data_addr;
         wdata_q <= data_wdata;
         wstrb_q <= data_wstrb;
      end
   end

   // load data only, write status is not passed up
   always_ff @(posedge aclk) begin
      if (data_op_done && !write_q) data_rdata <= data_op_rdata;
   end

endmodule

// File: src/fetch_port.sv
`timescale 1ns/10ps

module fetch_port
   import axi_bridge_pkg::*;
(
   input  logic              aclk,
   input  logic              rst_n,
   // core side
   input  logic              inst_req,
   input  logic [addr_w-1:0] inst_addr,
   input  logic              inst_cancel,
   output logic              inst_addr_ok,
   output logic              inst_valid,
   output logic [data_w-1:0] inst_rdata,
   // arbiter side
   output logic              fetch_rd_valid,
   output logic [addr_w-1:0] fetch_rd_addr,
   input  logic              fetch_rd_grant,
   input  logic              fetch_rd_done,
   input  logic [data_w-1:0] fetch_rd_data
);

   logic [slot_w-1:0] state;
   logic [slot_w-1:0] state_nxt;
   logic [addr_w-1:0] addr_q;
   logic              cancelled;
   logic              drop;

   // accept only into an empty slot
   assign inst_addr_ok   = inst_req & (state == slot_empty);
   assign fetch_rd_valid = (state == slot_wait_grant);
   assign fetch_rd_addr  = addr_q;

   // a cancel in the done cycle itself also kills the result
   assign drop = cancelled | inst_cancel;

   always_comb begin
      state_nxt = state;
      case (state)
         slot_empty: begin
            if (inst_addr_ok) state_nxt = slot_wait_grant;
         end
         slot_wait_grant: begin
            if (fetch_rd_grant) state_nxt = slot_wait_data;
         end
         slot_wait_data: begin
            if (fetch_rd_done) state_nxt = slot_empty;
         end
         default: state_nxt = slot_empty;
      endcase
   end

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= slot_empty;
         cancelled  <= 1'b0;
         inst_valid <= 1'b0;
      end else begin
         state <= state_nxt;
         // sticky until the slot drains
         if (fetch_rd_done) begin
            cancelled <= 1'b0;
         end else if (inst_cancel && state != slot_empty) begin
            cancelled <= 1'b1;
         end
         inst_valid <= fetch_rd_done & ~drop;
      end
   end

   // latched fetch address and returned word
   always_ff @(posedge aclk) begin
      if (inst_addr_ok) addr_q <= inst_addr;
      if (fetch_rd_done && !drop) inst_rdata <= fetch_rd_data;
   end

endmodule

// File: src/axi_bridge_pkg.sv
package axi_bridge_pkg;

   // core and bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = 4;
   localparam int id_w   = 4;
   localparam int resp_w = 2;

   // axi3 control field widths
   localparam int len_w   = 4;
   localparam int size_w  = 3;
   localparam int burst_w = 2;
   localparam int lock_w  = 2;
   localparam int cache_w = 4;
   localparam int prot_w  = 3;

   // one id per requester, responses routed back on these
   localparam logic [id_w-1:0] fetch_id = 4'd0;
   localparam logic [id_w-1:0] data_id  = 4'd1;

   // fixed transfer shape, single 4-byte incr beat
   localparam logic [size_w-1:0]  axi_size_word  = 3'd2;
   localparam logic [burst_w-1:0] axi_burst_incr = 2'b01;

   // request slot states shared by both ports
   localparam int                slot_w          = 2;
   localparam logic [slot_w-1:0] slot_empty      = 2'd0;
   localparam logic [slot_w-1:0] slot_wait_grant = 2'd1;
   localparam logic [slot_w-1:0] slot_wait_data  = 2'd2;

endpackage
